//--- design/alu_pkg.sv
`default_nettype none

package alu_pkg;

	localparam int data_width  = 16;
	localparam int group_width = 4;
	localparam int shamt_width = 4;

	typedef logic [data_width-1:0]  word_t;
	typedef logic [group_width-1:0] nibble_t;
	typedef logic [shamt_width-1:0] shamt_t; // low bits of operand b

	localparam word_t sat_max = 16'h7fff;
	localparam word_t sat_min = 16'h8000;

	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_xor = 3'd2,
		op_sll = 3'd3,
		op_sra = 3'd4,
		op_ror = 3'd5
	} alu_op_e;

	typedef struct packed {
		logic n; // negative
		logic z; // zero
		logic v; // signed overflow, result was clamped
	} alu_flags_t;

	typedef struct packed {
		alu_op_e op;
		word_t   a;
		word_t   b;
	} alu_req_t;

	typedef struct packed {
		word_t      result;
		alu_flags_t flags;
	} alu_rsp_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_exec = 2'd1,
		st_done = 2'd2
	} unit_state_e;

endpackage

`default_nettype wire

//--- design/cla_4b.sv
`timescale 1ns/1ps
`default_nettype none

module cla_4b
	import alu_pkg::*;
(
	input  nibble_t a,
	input  nibble_t b,
	input  logic    c_in,
	output nibble_t s,
	output logic    gg,
	output logic    pg
);

	nibble_t g; // per-bit generate
	nibble_t p; // per-bit propagate
	nibble_t c; // carry into each bit

	assign g = a & b;
	assign p = a | b;

	// all inner carries straight from c_in, no ripple
	assign c[0] = c_in;
	assign c[1] = g[0] | (p[0] & c_in);
	assign c[2] = g[1]
		| (p[1] & g[0])
		| (p[1] & p[0] & c_in);
	assign c[3] = g[2]
		| (p[2] & g[1])
		| (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & c_in);

	assign s = a ^ b ^ c;

	// group terms for the second lookahead level
	assign pg = &p;
	assign gg = g[3]
		| (p[3] & g[2])
		| (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]);

endmodule

`default_nettype wire

//--- design/cla_16b_sat.sv
`timescale 1ns/1ps
`default_nettype none

module cla_16b_sat
	import alu_pkg::*;
(
	input  word_t      a,
	input  word_t      b,
	input  logic       sub,
	output word_t      s,
	output alu_flags_t flags
);

	localparam int num_groups = data_width / group_width;

	word_t                 b_eff;    // b, or ~b for subtract
	word_t                 raw_sum;
	logic [num_groups-1:0] grp_g;
	logic [num_groups-1:0] grp_p;
	logic [num_groups-1:0] grp_c;    // carry into each group
	logic                  both_neg;
	logic                  both_pos;
	logic                  sat_neg;
	logic                  sat_pos;

	assign b_eff = sub ? ~b : b; // carry-in of one finishes the two's complement

	// second lookahead level over the group generate/propagate
	assign grp_c[0] = sub;
	assign grp_c[1] = grp_g[0] | (grp_p[0] & sub);
	assign grp_c[2] = grp_g[1]
		| (grp_p[1] & grp_g[0])
		| (grp_p[1] & grp_p[0] & sub);
	assign grp_c[3] = grp_g[2]
		| (grp_p[2] & grp_g[1])
		| (grp_p[2] & grp_p[1] & grp_g[0])
		| (grp_p[2] & grp_p[1] & grp_p[0] & sub);

	for (genvar i = 0; i < num_groups; i++) begin : g_grp
		cla_4b u_cla (
			.a    (a[i*group_width +: group_width]),
			.b    (b_eff[i*group_width +: group_width]),
			.c_in (grp_c[i]),
			.s    (raw_sum[i*group_width +: group_width]),
			.gg   (grp_g[i]),
			.pg   (grp_p[i])
		);
	end

	// overflow only when the effective operands share a sign
	assign both_neg = a[data_width-1] & b_eff[data_width-1];
	assign both_pos = ~a[data_width-1] & ~b_eff[data_width-1];
	assign sat_neg  = both_neg & ~raw_sum[data_width-1];
	assign sat_pos  = both_pos & raw_sum[data_width-1];

	always_comb begin
		if (sat_neg) begin
			s = sat_min;
		end else if (sat_pos) begin
			s = sat_max;
		end else begin
			s = raw_sum;
		end
	end

	assign flags.n = s[data_width-1];
	assign flags.z = ~|s;
	assign flags.v = sat_neg | sat_pos;

endmodule

`default_nettype wire

//--- design/shifter_16b.sv
`timescale 1ns/1ps
`default_nettype none

module shifter_16b
	import alu_pkg::*;
(
	input  word_t   a,
	input  shamt_t  shamt,
	input  alu_op_e op,
	output word_t   y
);

	word_t stage [shamt_width+1]; // stage[k] is the word before the 2**k step

	assign stage[0] = a;

	for (genvar k = 0; k < shamt_width; k++) begin : g_stage
		localparam int sh = 1 << k;

		word_t shifted;

		always_comb begin
			case (op)
				op_sll: begin
					shifted = {stage[k][data_width-1-sh:0], {sh{1'b0}}};
				end
				op_sra: begin
					shifted = {{sh{stage[k][data_width-1]}}, stage[k][data_width-1:sh]};
				end
				op_ror: begin
					shifted = {stage[k][sh-1:0], stage[k][data_width-1:sh]};
				end
				default: begin
					shifted = stage[k]; // not a shift, leave the word alone
				end
			endcase
		end

		assign stage[k+1] = shamt[k] ? shifted : stage[k];
	end

	assign y = stage[shamt_width];

endmodule

`default_nettype wire

//--- design/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core
	import alu_pkg::*;
(
	input  alu_req_t   req,
	input  alu_flags_t flags_cur,
	output alu_rsp_t   rsp
);

	logic       do_sub;
	word_t      sum;
	alu_flags_t add_flags;
	shamt_t     sh_amt;
	word_t      shifted;
	word_t      xor_res;

	assign do_sub  = (req.op == op_sub);
	assign sh_amt  = req.b[shamt_width-1:0];
	assign xor_res = req.a ^ req.b;

	cla_16b_sat u_add (
		.a     (req.a),
		.b     (req.b),
		.sub   (do_sub),
		.s     (sum),
		.flags (add_flags)
	);

	shifter_16b u_shift (
		.a     (req.a),
		.shamt (sh_amt),
		.op    (req.op),
		.y     (shifted)
	);

	always_comb begin
		rsp.flags = flags_cur;
		case (req.op)
			op_add, op_sub: begin
				rsp.result = sum;
				rsp.flags  = add_flags;
			end
			op_xor: begin
				rsp.result = xor_res;
			end
			op_sll, op_sra, op_ror: begin
				rsp.result = shifted;
			end
			default: begin
				rsp.result = '0; // unused encodings
			end
		endcase

		// logic ops and shifts only touch z, n and v stay sticky
		if (req.op != op_add && req.op != op_sub) begin
			rsp.flags.z = ~|rsp.result;
		end
	end

endmodule

`default_nettype wire

//--- design/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
	import alu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     req,
	input  alu_req_t req_data,
	output logic     ack,
	output alu_rsp_t rsp
);

	unit_state_e state;
	alu_req_t    req_q;     // operands held for the exec cycle
	word_t       result_q;
	alu_flags_t  flags_q;   // N/Z/V flag register
	alu_rsp_t    core_rsp;

	alu_core u_core (
		.req       (req_q),
		.flags_cur (flags_q),
		.rsp       (core_rsp)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= st_idle;
			ack      <= 1'b0;
			result_q <= '0;
			flags_q  <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (req) begin
						state <= st_exec;
					end
				end
				st_exec: begin
					result_q <= core_rsp.result;
					flags_q  <= core_rsp.flags;
					ack      <= 1'b1;
					state    <= st_done;
				end
				st_done: begin
					if (!req) begin // requester has seen ack
						ack   <= 1'b0;
						state <= st_idle;
					end
				end
				default: begin
					ack   <= 1'b0;
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && req) begin
			req_q <= req_data;
		end
	end

	assign rsp.result = result_q;
	assign rsp.flags  = flags_q; // visible between transactions too

	// ack only answers a request that started two edges earlier
	a_ack_needs_req: assert property (
		@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req, 2)
	) else $error("ack rose without a request");

	a_data_stable: assert property (
		@(posedge clk) disable iff (rst)
		(state == st_exec && req) |-> $stable(req_data)
	) else $error("req_data changed while req was high");

	a_idle_no_ack: assert property (
		@(posedge clk) disable iff (rst)
		(state == st_idle) |-> !ack
	) else $error("ack high in idle state");

endmodule

`default_nettype wire

//--- test/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb
	import alu_pkg::*;
;

	localparam int reset_cycles = 16;
	localparam int num_pairs    = 8;
	localparam int num_trans    = (3 + 2*num_pairs) + (4 + 2*num_pairs) + 7 + 3*16*2;
	localparam int cycle_limit  = 40*num_trans + reset_cycles;

	logic       clk;
	logic       rst;
	logic       req;
	alu_req_t   req_data;
	logic       ack;
	alu_rsp_t   rsp;

	logic [31:0] lfsr;
	alu_flags_t  exp_flags;  // flag register as the model sees it
	int          cycle_count;

	alu_unit dut0 (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.req_data (req_data),
		.ack      (ack),
		.rsp      (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb) begin
			s = s ^ 32'h80200003;
		end
		return s;
	endfunction

	task automatic rand_word(input int nbits, output word_t w);
		w = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			w = {w[14:0], lfsr[0]};
		end
	endtask

	function automatic alu_flags_t nzv(input logic n, input logic z, input logic v);
		alu_flags_t f;
		f.n = n;
		f.z = z;
		f.v = v;
		return f;
	endfunction

	// expected response from the saturation and flag rules
	function automatic alu_rsp_t model_alu(input alu_req_t r, input alu_flags_t cur);
		alu_rsp_t    m;
		int          sa;
		int          sb;
		int          total;
		logic [31:0] dbl;
		sa = $signed(r.a);
		sb = $signed(r.b);
		dbl = {r.a, r.a};
		m.flags = cur;
		m.result = '0;
		case (r.op)
			op_add, op_sub: begin
				total = (r.op == op_add) ? sa + sb : sa - sb;
				m.flags.v = 1'b0;
				if (total > 32767) begin
					m.result = 16'h7fff;
					m.flags.v = 1'b1;
				end else if (total < -32768) begin
					m.result = 16'h8000;
					m.flags.v = 1'b1;
				end else begin
					m.result = total[15:0];
				end
				m.flags.n = m.result[15];
			end
			op_xor: m.result = r.a ^ r.b;
			op_sll: m.result = r.a << r.b[3:0];
			op_sra: m.result = $signed(r.a) >>> r.b[3:0];
			op_ror: begin
				dbl = dbl >> r.b[3:0]; // wrapped bits come from the upper copy
				m.result = dbl[15:0];
			end
			default: m.result = '0;
		endcase
		m.flags.z = (m.result == '0);
		return m;
	endfunction

	task automatic check_true(input logic ok, input string msg);
		assert (ok) else begin
			$display("CHECK FAILED at %0t: %s", $time, msg);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic expect_rsp(input alu_rsp_t got, input word_t res, input alu_flags_t fl,
			input string what);
		check_true(got.result == res && got.flags == fl,
			$sformatf("%s: got %h nzv=%b, expected %h nzv=%b",
				what, got.result, got.flags, res, fl));
	endtask

	// one full four-phase transaction with a random hold of 0 to 7 cycles
	task automatic do_op(input alu_op_e op, input word_t a, input word_t b,
			output alu_rsp_t got);
		alu_req_t r;
		alu_rsp_t exp;
		word_t    hold;
		int       edges;
		r.op = op;
		r.a  = a;
		r.b  = b;
		exp = model_alu(r, exp_flags);
		req_data = r;
		req = 1'b1;
		edges = 0;
		do begin
			@(posedge clk);
			#2;
			edges++;
		end while (!ack);
		check_true(edges == 2, $sformatf("ack rose after %0d edges, expected 2", edges));
		got = rsp;
		check_true(got == exp, $sformatf("op %s a=%h b=%h: got %h nzv=%b, expected %h nzv=%b",
			op.name(), a, b, got.result, got.flags, exp.result, exp.flags));
		exp_flags = exp.flags;
		rand_word(3, hold);
		repeat (hold) begin
			@(posedge clk);
			#2;
			check_true(ack && rsp == got, "ack or rsp changed while req was held high");
		end
		req = 1'b0;
		@(posedge clk);
		#2;
		check_true(!ack, "ack did not drop one edge after req fell");
		check_true(rsp.flags == exp_flags, "flags changed after the transaction");
	endtask

	task automatic handshake_reset();
		check_true(!ack, "ack high after reset");
		check_true(rsp.flags == 3'b000 && rsp.result == '0, "flags or result not zero after reset");
	endtask

	task automatic plain_arith();
		alu_rsp_t got;
		word_t    t;
		word_t    a;
		word_t    b;
		do_op(op_add, 16'h000f, 16'h0001, got);
		expect_rsp(got, 16'h0010, nzv(0, 0, 0), "000f+1");
		do_op(op_add, 16'h0fff, 16'h0001, got);
		expect_rsp(got, 16'h1000, nzv(0, 0, 0), "0fff+1");
		do_op(op_sub, 16'd5, 16'd7, got);
		expect_rsp(got, 16'hfffe, nzv(1, 0, 0), "5-7");
		for (int i = 0; i < num_pairs; i++) begin
			rand_word(15, t);
			a = {t[14], t[14:0]}; // 15-bit signed range cannot overflow
			rand_word(15, t);
			b = {t[14], t[14:0]};
			do_op(op_add, a, b, got);
			check_true(got.result == word_t'(a + b) && !got.flags.v, "random add not exact");
			do_op(op_sub, a, b, got);
			check_true(got.result == word_t'(a - b) && !got.flags.v, "random sub not exact");
		end
	endtask

	task automatic saturation_cases();
		alu_rsp_t got;
		word_t    a;
		word_t    b;
		do_op(op_add, 16'h7fff, 16'h0001, got);
		expect_rsp(got, 16'h7fff, nzv(0, 0, 1), "7fff+1");
		do_op(op_add, 16'h4000, 16'h4000, got);
		expect_rsp(got, 16'h7fff, nzv(0, 0, 1), "4000+4000");
		do_op(op_sub, 16'h8000, 16'h0001, got);
		expect_rsp(got, 16'h8000, nzv(1, 0, 1), "8000-1");
		do_op(op_add, 16'h8000, 16'h8000, got);
		expect_rsp(got, 16'h8000, nzv(1, 0, 1), "8000+8000");
		for (int i = 0; i < num_pairs; i++) begin
			rand_word(16, a);
			rand_word(16, b);
			do_op(op_add, a, b, got);
			do_op(op_sub, a, b, got);
		end
	endtask

	task automatic flag_cases();
		alu_rsp_t got;
		word_t    x;
		rand_word(16, x);
		do_op(op_sub, 16'h1234, 16'h1234, got);
		expect_rsp(got, 16'h0000, nzv(0, 1, 0), "x-x");
		do_op(op_sub, 16'h8000, 16'h8000, got);
		expect_rsp(got, 16'h0000, nzv(0, 1, 0), "8000-8000");
		do_op(op_sub, x, x, got);
		expect_rsp(got, 16'h0000, nzv(0, 1, 0), "random x-x");
		// xor keeps n and v from the overflowing add
		do_op(op_add, 16'h8000, 16'h8000, got);
		do_op(op_xor, 16'h1234, 16'h1234, got);
		expect_rsp(got, 16'h0000, nzv(1, 1, 1), "xor after negative overflow");
		do_op(op_add, 16'h7fff, 16'h0001, got);
		do_op(op_xor, 16'h00ff, 16'h0f0f, got);
		expect_rsp(got, 16'h0ff0, nzv(0, 0, 1), "xor after positive overflow");
	endtask

	task automatic shift_sweep();
		alu_rsp_t got;
		alu_op_e  ops [3];
		word_t    w;
		word_t    hi;
		ops[0] = op_sll;
		ops[1] = op_sra;
		ops[2] = op_ror;
		for (int k = 0; k < 3; k++) begin
			for (int sh = 0; sh < 16; sh++) begin
				rand_word(12, hi);
				do_op(ops[k], 16'h8001, {hi[11:0], 4'(sh)}, got); // upper b bits are ignored
				rand_word(16, w);
				do_op(ops[k], w, {hi[11:0], 4'(sh)}, got);
			end
		end
	endtask

	initial begin
		lfsr        = 32'h1e1d;
		exp_flags   = '0;
		cycle_count = 0;
		rst         = 1'b1;
		req         = 1'b0;
		req_data    = '0;
		repeat (reset_cycles) @(posedge clk);
		#2;
		rst = 1'b0;
		handshake_reset();
		plain_arith();
		saturation_cases();
		flag_cases();
		shift_sweep();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
design/alu_pkg.sv
design/cla_4b.sv
design/cla_16b_sat.sv
design/shifter_16b.sv
design/alu_core.sv
design/alu_unit.sv
test/alu_tb.sv

//--- Bender.yml
package:
  name: alu_unit

sources:
  - design/alu_pkg.sv
  - design/cla_4b.sv
  - design/cla_16b_sat.sv
  - design/shifter_16b.sv
  - design/alu_core.sv
  - design/alu_unit.sv
  - target: test
    files:
      - test/alu_tb.sv
